/* desc_pkg.sv */
package desc_pkg;

  // ----------------------------------------------------------------------
  // table and bus widths
  // ----------------------------------------------------------------------
  localparam int ADDR_W     = 3;
  localparam int ENTRIES    = 1 << ADDR_W;  // eight descriptors
  localparam int CHAN_W     = 2;
  localparam int CHANNELS   = 1 << CHAN_W;
  localparam int DESC_W     = 66;           // tag + 64-bit payload
  localparam int BUS_W      = 64;
  localparam int CPU_W      = 32;
  localparam int BYTE_LEN_W = 24;
  localparam int WORD_LEN_W = 22;

  // ----------------------------------------------------------------------
  // descriptor field positions
  // ----------------------------------------------------------------------
  // origin tag in 65..64, bit 64 marks a DMA-written entry
  localparam int STARTED_BIT = 64;

  // control byte
  localparam int CTRL_MSB   = 63;
  localparam int CTRL_LSB   = 56;
  localparam int ATOMIC_BIT = 61;  // guard for DMA writes
  localparam int DIR_BIT    = 58;
  localparam int CHAN_MSB   = 57;
  localparam int CHAN_LSB   = 56;

  // byte length as the CPU presents it
  localparam int LEN_MSB = 55;
  localparam int LEN_LSB = 32;

  // CPU read returns the upper half
  localparam int CPU_RD_LSB = 32;

  // low address bits cleared on CPU writes
  localparam int ALIGN_BITS = 3;

  localparam logic [1:0] TAG_CPU = 2'b00;
  localparam logic [1:0] TAG_DMA = 2'b01;

  // ----------------------------------------------------------------------
  // vector types
  // ----------------------------------------------------------------------
  typedef logic [ADDR_W-1:0]     desc_addr_t;
  typedef logic [DESC_W-1:0]     desc_word_t;
  typedef logic [BUS_W-1:0]      bus_word_t;
  typedef logic [CPU_W-1:0]      cpu_word_t;
  typedef logic [BYTE_LEN_W-1:0] byte_len_t;
  typedef logic [WORD_LEN_W-1:0] word_len_t;
  typedef logic [CHAN_W-1:0]     chan_t;

endpackage

/* desc_write_path.sv */
`timescale 1ns/1ps

module desc_write_path (
  input  logic                 CLK,
  input  logic                 RST,
  // CPU side
  input  logic                 write_cpu,
  input  desc_pkg::desc_addr_t addr_cpu,
  input  desc_pkg::bus_word_t  in_cpu,
  output logic                 write_cpu_ack,
  // DMA side
  input  logic                 write_dma,
  input  desc_pkg::desc_addr_t w_addr_dma,
  input  desc_pkg::bus_word_t  in_dma,
  // registered request towards the store
  output logic                 wr_valid,
  output logic                 wr_from_dma,
  output desc_pkg::desc_addr_t wr_addr,
  output desc_pkg::desc_word_t wr_word,
  output desc_pkg::byte_len_t  wr_byte_len
);

  import desc_pkg::*;

  byte_len_t  cpu_len;
  word_len_t  cpu_len_words;
  desc_word_t cpu_word;
  desc_word_t dma_word;
  desc_word_t next_word;
  desc_addr_t next_addr;
  logic       cpu_accept;
  logic       any_accept;

  // ----------------------------------------------------------------------
  // arbitration
  // ----------------------------------------------------------------------
  // DMA always wins, CPU waits out its own ack cycle
  assign cpu_accept = write_cpu && !write_dma && !write_cpu_ack;
  assign any_accept = write_dma || cpu_accept;

  // ----------------------------------------------------------------------
  // length rounding and packing
  // ----------------------------------------------------------------------
  assign cpu_len = in_cpu[LEN_MSB:LEN_LSB];

  // bytes to 32-bit words, any partial word counts
  assign cpu_len_words = cpu_len[BYTE_LEN_W-1:2] + word_len_t'(|cpu_len[1:0]);

  assign cpu_word = {
    TAG_CPU,
    in_cpu[CTRL_MSB:CTRL_LSB],
    cpu_len_words,
    2'b00,                              // spare bits 33..32
    in_cpu[CPU_W-1:ALIGN_BITS],
    {ALIGN_BITS{1'b0}}                  // 8-byte aligned address
  };

  assign dma_word = {TAG_DMA, in_dma};  // marks the entry as started

  assign next_word = write_dma ? dma_word : cpu_word;
  assign next_addr = write_dma ? w_addr_dma : addr_cpu;

  // ----------------------------------------------------------------------
  // request register, one cycle ahead of the commit
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      write_cpu_ack <= 1'b0;
      wr_valid      <= 1'b0;
      wr_from_dma   <= 1'b0;
    end
    else
    begin
      write_cpu_ack <= cpu_accept;   // single-cycle pulse
      wr_valid      <= any_accept;
      wr_from_dma   <= write_dma;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (any_accept)
    begin
      wr_addr     <= next_addr;
      wr_word     <= next_word;
      wr_byte_len <= cpu_len;        // only kept by the store on CPU commits
    end
  end

  // ack is a pulse, the CPU needs a fresh acceptance for every write
  a_ack_single : assert property (
    @(posedge CLK) disable iff (!RST)
    write_cpu_ack |=> !write_cpu_ack
  ) else $error("write_cpu_ack high for two cycles");

endmodule

/* desc_store.sv */
`timescale 1ns/1ps

module desc_store (
  input  logic                 CLK,
  input  logic                 RST,
  // read requests
  input  logic                 read_cpu,
  input  logic                 read_dma,
  input  desc_pkg::desc_addr_t addr_cpu,
  input  desc_pkg::desc_addr_t r_addr_dma,
  // registered write request
  input  logic                 wr_valid,
  input  logic                 wr_from_dma,
  input  desc_pkg::desc_addr_t wr_addr,
  input  desc_pkg::desc_word_t wr_word,
  input  desc_pkg::byte_len_t  wr_byte_len,
  // read results
  output logic                 read_cpu_ack,
  output desc_pkg::cpu_word_t  out_cpu,
  output desc_pkg::bus_word_t  out_dma,
  // channel launch request
  output logic                 launch,
  output desc_pkg::byte_len_t  launch_len
);

  import desc_pkg::*;

  desc_word_t desc_mem [ENTRIES];
  byte_len_t  len_mem  [ENTRIES];

  logic       stored_atomic;
  logic       started;
  logic       commit;
  logic       cpu_rd_accept;
  logic       read_dma_q;
  desc_addr_t read_addr;
  desc_word_t read_word;

  // ----------------------------------------------------------------------
  // commit rule
  // ----------------------------------------------------------------------
  assign stored_atomic = desc_mem[wr_addr][ATOMIC_BIT];
  assign started       = desc_mem[wr_addr][STARTED_BIT];

  // DMA writes land only if their atomic strobe matches the entry
  assign commit = wr_valid && (!wr_from_dma || (wr_word[ATOMIC_BIT] == stored_atomic));

  // first effective DMA write after a CPU write
  assign launch     = commit && wr_from_dma && !started;
  assign launch_len = len_mem[wr_addr];

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      for (int i = 0; i < ENTRIES; i++)
      begin
        desc_mem[i] <= '0;
        len_mem[i]  <= '0;
      end
    end
    else if (commit)
    begin
      desc_mem[wr_addr] <= wr_word;
      if (!wr_from_dma)
        len_mem[wr_addr] <= wr_byte_len;  // byte length only from the CPU
    end
  end

  // ----------------------------------------------------------------------
  // read side, DMA has priority
  // ----------------------------------------------------------------------
  assign cpu_rd_accept = read_cpu && !read_dma && !read_cpu_ack;
  assign read_word     = desc_mem[read_addr];

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      read_dma_q   <= 1'b0;
      read_cpu_ack <= 1'b0;
      read_addr    <= '0;
      out_dma      <= '0;
      out_cpu      <= '0;
    end
    else
    begin
      read_dma_q   <= read_dma;
      read_cpu_ack <= cpu_rd_accept;

      if (read_dma)
        read_addr <= r_addr_dma;
      else if (cpu_rd_accept)
        read_addr <= addr_cpu;

      // outputs hold between reads
      if (read_dma_q)
        out_dma <= read_word[BUS_W-1:0];
      if (read_cpu_ack)
        out_cpu <= read_word[CPU_RD_LSB +: CPU_W];
    end
  end

  a_cpu_read_yields : assert property (
    @(posedge CLK) disable iff (!RST)
    $rose(read_cpu_ack) |-> !$past(read_dma)
  ) else $error("CPU read acknowledged over a DMA read");

endmodule

/* channel_launch.sv */
`timescale 1ns/1ps

module channel_launch (
  input  logic                CLK,
  input  logic                RST,
  input  logic                launch,
  input  desc_pkg::chan_t     launch_chan,
  input  logic                launch_dir,
  input  desc_pkg::byte_len_t launch_len,
  // channel 0
  output desc_pkg::byte_len_t len_0,
  output logic                dir_0,
  output logic                en_stb_0,
  // channel 1
  output desc_pkg::byte_len_t len_1,
  output logic                dir_1,
  output logic                en_stb_1,
  // channel 2
  output desc_pkg::byte_len_t len_2,
  output logic                dir_2,
  output logic                en_stb_2,
  // channel 3
  output desc_pkg::byte_len_t len_3,
  output logic                dir_3,
  output logic                en_stb_3
);

  import desc_pkg::*;

  byte_len_t         len_q [CHANNELS];
  logic              dir_q [CHANNELS];
  logic              stb_q [CHANNELS];
  logic [CHANNELS-1:0] stb_vec;

  // ----------------------------------------------------------------------
  // launch registers, one set per channel
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      for (int c = 0; c < CHANNELS; c++)
      begin
        len_q[c] <= '0;
        dir_q[c] <= 1'b0;
        stb_q[c] <= 1'b0;
      end
    end
    else if (launch)
    begin
      len_q[launch_chan] <= launch_len;
      dir_q[launch_chan] <= launch_dir;
      stb_q[launch_chan] <= !stb_q[launch_chan];  // toggle, not a pulse
    end
  end

  assign len_0 = len_q[0];
  assign len_1 = len_q[1];
  assign len_2 = len_q[2];
  assign len_3 = len_q[3];

  assign dir_0 = dir_q[0];
  assign dir_1 = dir_q[1];
  assign dir_2 = dir_q[2];
  assign dir_3 = dir_q[3];

  assign en_stb_0 = stb_q[0];
  assign en_stb_1 = stb_q[1];
  assign en_stb_2 = stb_q[2];
  assign en_stb_3 = stb_q[3];

  assign stb_vec = {en_stb_3, en_stb_2, en_stb_1, en_stb_0};

  a_one_launch : assert property (
    @(posedge CLK) disable iff (!RST)
    $onehot0(stb_vec ^ $past(stb_vec))
  ) else $error("more than one channel launched in a cycle");

endmodule

/* desc_mem_top.sv */
`timescale 1ns/1ps

module desc_mem_top (
  input  logic                 CLK,
  input  logic                 RST,
  // ----------------------------------------------------------------------
  // CPU port
  input  logic                 read_cpu,
  input  logic                 write_cpu,
  output logic                 read_cpu_ack,
  output logic                 write_cpu_ack,
  input  desc_pkg::desc_addr_t addr_cpu,
  input  desc_pkg::bus_word_t  in_cpu,
  output desc_pkg::cpu_word_t  out_cpu,
  // ----------------------------------------------------------------------
  // DMA port
  input  logic                 read_dma,
  input  logic                 write_dma,
  input  desc_pkg::desc_addr_t r_addr_dma,
  input  desc_pkg::desc_addr_t w_addr_dma,
  input  desc_pkg::bus_word_t  in_dma,
  output desc_pkg::bus_word_t  out_dma,
  // ----------------------------------------------------------------------
  // channel launch outputs
  output desc_pkg::byte_len_t  len_0,
  output logic                 dir_0,
  output logic                 en_stb_0,
  output desc_pkg::byte_len_t  len_1,
  output logic                 dir_1,
  output logic                 en_stb_1,
  output desc_pkg::byte_len_t  len_2,
  output logic                 dir_2,
  output logic                 en_stb_2,
  output desc_pkg::byte_len_t  len_3,
  output logic                 dir_3,
  output logic                 en_stb_3
);

  import desc_pkg::*;

  logic       wr_valid;
  logic       wr_from_dma;
  desc_addr_t wr_addr;
  desc_word_t wr_word;
  byte_len_t  wr_byte_len;
  logic       launch;
  byte_len_t  launch_len;

  desc_write_path u_write_path (
    .CLK, .RST,
    .write_cpu, .addr_cpu, .in_cpu, .write_cpu_ack,
    .write_dma, .w_addr_dma, .in_dma,
    .wr_valid, .wr_from_dma, .wr_addr, .wr_word, .wr_byte_len
  );

  desc_store u_store (
    .CLK, .RST,
    .read_cpu, .read_dma, .addr_cpu, .r_addr_dma,
    .wr_valid, .wr_from_dma, .wr_addr, .wr_word, .wr_byte_len,
    .read_cpu_ack, .out_cpu, .out_dma,
    .launch, .launch_len
  );

  // channel and direction come straight from the word being committed
  channel_launch u_launch (
    .CLK, .RST,
    .launch,
    .launch_chan (wr_word[CHAN_MSB:CHAN_LSB]),
    .launch_dir  (wr_word[DIR_BIT]),
    .launch_len,
    .len_0, .dir_0, .en_stb_0,
    .len_1, .dir_1, .en_stb_1,
    .len_2, .dir_2, .en_stb_2,
    .len_3, .dir_3, .en_stb_3
  );

endmodule

/* desc_checker.sv */
`timescale 1ns/1ps

module desc_checker (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 read_cpu,
  input  logic                 write_cpu,
  input  desc_pkg::desc_addr_t addr_cpu,
  input  desc_pkg::bus_word_t  in_cpu,
  input  logic                 read_dma,
  input  logic                 write_dma,
  input  desc_pkg::desc_addr_t r_addr_dma,
  input  desc_pkg::desc_addr_t w_addr_dma,
  input  desc_pkg::bus_word_t  in_dma,
  input  logic                 read_cpu_ack,
  input  logic                 write_cpu_ack,
  input  desc_pkg::cpu_word_t  out_cpu,
  input  desc_pkg::bus_word_t  out_dma,
  input  desc_pkg::byte_len_t  len_0, len_1, len_2, len_3,
  input  logic                 dir_0, dir_1, dir_2, dir_3,
  input  logic                 en_stb_0, en_stb_1, en_stb_2, en_stb_3,
  output int                   errors,
  output int                   checks
);

  import desc_pkg::*;

  desc_word_t model_desc [ENTRIES];
  byte_len_t  model_len  [ENTRIES];
  byte_len_t  exp_len    [CHANNELS];
  logic       exp_dir    [CHANNELS];
  logic       exp_stb    [CHANNELS];
  logic       wr_pend;       // write registered, commits at the next edge
  logic       wr_pend_dma;
  desc_addr_t wr_pend_addr;
  desc_word_t wr_pend_word;
  byte_len_t  wr_pend_len;
  logic       exp_wack;
  logic       exp_rack;
  logic       rd_dma_pend;
  desc_addr_t rd_dma_addr;
  desc_addr_t rd_cpu_addr;
  bus_word_t  exp_out_dma;
  cpu_word_t  exp_out_cpu;
  logic       armed;         // model valid once a reset was seen

  initial
  begin
    errors = 0;
    checks = 0;
    armed  = 1'b0;
  end

  // control byte, length rounded up to words, 8-byte aligned address
  function automatic desc_word_t pack_cpu_word(input bus_word_t data);
    logic [BYTE_LEN_W:0] words;
    desc_word_t          w;
    words    = ({1'b0, data[LEN_MSB:LEN_LSB]} + 3) >> 2;
    w        = '0;
    w[63:56] = data[63:56];
    w[55:34] = words[WORD_LEN_W-1:0];
    w[31:3]  = data[31:3];
    return w;
  endfunction

  task automatic compare_value(input string name, input logic [65:0] expected,
                               input logic [65:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("CHECK FAILED at %0d ns: %s expected %h actual %h",
               $time, name, expected, actual);
    end
  endtask

  task automatic clear_model();
    for (int i = 0; i < ENTRIES; i++)
    begin
      model_desc[i] = '0;
      model_len[i]  = '0;
    end
    for (int c = 0; c < CHANNELS; c++)
    begin
      exp_len[c] = '0;
      exp_dir[c] = 1'b0;
      exp_stb[c] = 1'b0;
    end
    wr_pend     = 1'b0;
    exp_wack    = 1'b0;
    exp_rack    = 1'b0;
    rd_dma_pend = 1'b0;
    exp_out_dma = '0;
    exp_out_cpu = '0;
  endtask

  task automatic compare_outputs();
    byte_len_t act_len [CHANNELS];
    logic      act_dir [CHANNELS];
    logic      act_stb [CHANNELS];
    act_len = '{len_0, len_1, len_2, len_3};
    act_dir = '{dir_0, dir_1, dir_2, dir_3};
    act_stb = '{en_stb_0, en_stb_1, en_stb_2, en_stb_3};
    compare_value("write_cpu_ack", exp_wack, write_cpu_ack);
    compare_value("read_cpu_ack", exp_rack, read_cpu_ack);
    compare_value("out_cpu", exp_out_cpu, out_cpu);
    compare_value("out_dma", exp_out_dma, out_dma);
    for (int c = 0; c < CHANNELS; c++)
    begin
      compare_value($sformatf("len_%0d", c), exp_len[c], act_len[c]);
      compare_value($sformatf("dir_%0d", c), exp_dir[c], act_dir[c]);
      compare_value($sformatf("en_stb_%0d", c), exp_stb[c], act_stb[c]);
    end
  endtask

  // ----------------------------------------------------------------------
  // state after the coming rising edge
  // ----------------------------------------------------------------------
  task automatic predict_edge();
    logic  commit;
    logic  cpu_wr;
    chan_t ch;
    // reads see the table before this edge's commit
    if (rd_dma_pend)
      exp_out_dma = model_desc[rd_dma_addr][63:0];
    if (exp_rack)
      exp_out_cpu = model_desc[rd_cpu_addr][63:32];
    commit = wr_pend && (!wr_pend_dma ||
             wr_pend_word[ATOMIC_BIT] == model_desc[wr_pend_addr][ATOMIC_BIT]);
    if (commit && wr_pend_dma && !model_desc[wr_pend_addr][STARTED_BIT])
    begin
      ch          = wr_pend_word[57:56];
      exp_len[ch] = model_len[wr_pend_addr];
      exp_dir[ch] = wr_pend_word[DIR_BIT];
      exp_stb[ch] = !exp_stb[ch];
    end
    if (commit)
    begin
      model_desc[wr_pend_addr] = wr_pend_word;
      if (!wr_pend_dma)
        model_len[wr_pend_addr] = wr_pend_len;
    end
    cpu_wr       = write_cpu && !write_dma && !exp_wack;
    wr_pend      = write_dma || cpu_wr;
    wr_pend_dma  = write_dma;
    wr_pend_addr = write_dma ? w_addr_dma : addr_cpu;
    wr_pend_word = write_dma ? {2'b01, in_dma} : pack_cpu_word(in_cpu);
    wr_pend_len  = in_cpu[LEN_MSB:LEN_LSB];
    exp_wack     = cpu_wr;
    rd_dma_pend  = read_dma;
    if (read_dma)
      rd_dma_addr = r_addr_dma;
    if (read_cpu && !read_dma && !exp_rack)
      rd_cpu_addr = addr_cpu;
    exp_rack = read_cpu && !read_dma && !exp_rack;
  endtask

  // mid-cycle, inputs and outputs both settled
  always @(negedge CLK)
  begin
    if (armed)
      compare_outputs();
    if (!RST)
    begin
      clear_model();
      armed = 1'b1;
    end
    else if (armed)
      predict_edge();
  end

endmodule

/* tb_desc_mem.sv */
`timescale 1ns/1ps

module tb_desc_mem;

  import desc_pkg::*;

  localparam int PERIOD      = 40;
  localparam int RAND_CYCLES = 600;
  localparam int DRAIN       = 8;                  // lets the CPU finish its last request
  localparam int LIMIT       = RAND_CYCLES + 100;  // watchdog limit in cycles

  logic       CLK;
  logic       RST;
  logic       read_cpu;
  logic       write_cpu;
  logic       read_cpu_ack;
  logic       write_cpu_ack;
  desc_addr_t addr_cpu;
  bus_word_t  in_cpu;
  cpu_word_t  out_cpu;
  logic       read_dma;
  logic       write_dma;
  desc_addr_t r_addr_dma;
  desc_addr_t w_addr_dma;
  bus_word_t  in_dma;
  bus_word_t  out_dma;
  byte_len_t  len_0, len_1, len_2, len_3;
  logic       dir_0, dir_1, dir_2, dir_3;
  logic       en_stb_0, en_stb_1, en_stb_2, en_stb_3;
  int         errors;
  int         checks;
  integer     seed;

  desc_mem_top DUT (.*);

  desc_checker u_checker (.*);

  always #(PERIOD/2) CLK = ~CLK;

  // ----------------------------------------------------------------------
  // one cycle of random requests
  // ----------------------------------------------------------------------
  task automatic drive_cycle(input logic quiet);
    integer pick;
    logic   mismatch;
    // CPU holds a request until its ack shows up
    if ((write_cpu && write_cpu_ack) || (read_cpu && read_cpu_ack))
    begin
      write_cpu = 1'b0;
      read_cpu  = 1'b0;
    end
    if (!write_cpu && !read_cpu && !quiet)
    begin
      pick     = $unsigned($random(seed)) % 8;
      addr_cpu = $random(seed);
      in_cpu   = {$random(seed), $random(seed)};
      write_cpu = (pick < 3);
      read_cpu  = (pick >= 3) && (pick < 5);
    end
    write_dma = 1'b0;
    read_dma  = 1'b0;
    if (!quiet)
    begin
      pick       = $unsigned($random(seed)) % 8;
      w_addr_dma = $random(seed);
      r_addr_dma = $random(seed);
      in_dma     = {$random(seed), $random(seed)};
      mismatch   = $random(seed);
      write_dma  = (pick < 3);
      read_dma   = (pick >= 2) && (pick < 5);  // pick 2 gives both at once
      // half the writes carry the stored atomic bit
      in_dma[ATOMIC_BIT] = u_checker.model_desc[w_addr_dma][ATOMIC_BIT] ^ mismatch;
    end
  endtask

  initial
  begin
    seed       = 57;
    CLK        = 1'b0;
    RST        = 1'b0;
    read_cpu   = 1'b0;
    write_cpu  = 1'b0;
    addr_cpu   = '0;
    in_cpu     = '0;
    read_dma   = 1'b0;
    write_dma  = 1'b0;
    r_addr_dma = '0;
    w_addr_dma = '0;
    in_dma     = '0;
    repeat (2) @(posedge CLK);
    #2;
    RST = 1'b1;
    for (int n = 0; n < RAND_CYCLES + DRAIN; n++)
    begin
      @(posedge CLK);
      #2;
      drive_cycle(n >= RAND_CYCLES);
    end
    repeat (2) @(posedge CLK);
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  // watchdog
  initial
  begin
    #(LIMIT * PERIOD);
    $display("timeout: run did not finish within %0d cycles", LIMIT);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* src.f */
desc_pkg.sv
desc_write_path.sv
desc_store.sv
channel_launch.sv
desc_mem_top.sv
desc_checker.sv
tb_desc_mem.sv

/* Bender.yml */
package:
  name: desc_mem

sources:
  - desc_pkg.sv
  - desc_write_path.sv
  - desc_store.sv
  - channel_launch.sv
  - desc_mem_top.sv
  - target: simulation
    files:
      - desc_checker.sv
      - tb_desc_mem.sv
